// File: tb/conv_stim.txt
// job count, then per job: fm_dim wt_off ifm_off ofm_off stall status_err, 9 weights,
// fm_dim^2 input words, fm_dim^2 expected output words (hex, raster order)
7
4 100 200 300 0 0  0 0 0 0 1 0 0 0 0
1 2 3 4 5 6 7 8 9 a b c d e f 10
1 2 3 4 5 6 7 8 9 a b c d e f 10
5 400 500 600 0 0  3 fffffffe 5 7 4 ffffffff 2 6 fffffffd
1 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 2
4 7 0 0 0  fffffffe 3 0 0 0  0 0 0 0 0  0 0 0 fffffffa c  0 0 0 fffffffe 8
8 700 800 900 0 0  1 1 1 1 1 1 1 1 1
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1
4 6 6 6 6 6 6 4  6 9 9 9 9 9 9 6  6 9 9 9 9 9 9 6  6 9 9 9 9 9 9 6
6 9 9 9 9 9 9 6  6 9 9 9 9 9 9 6  6 9 9 9 9 9 9 6  4 6 6 6 6 6 6 4
1 a00 b00 c00 0 0  7 7 7 7 5 7 7 7 7
3
f
5 d00 e00 f00 1 0  3 fffffffe 5 7 4 ffffffff 2 6 fffffffd
1 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 2
4 7 0 0 0  fffffffe 3 0 0 0  0 0 0 0 0  0 0 0 fffffffa c  0 0 0 fffffffe 8
4 1000 1100 1200 1 1  0 0 0 0 1 0 0 0 0
1 2 3 4 5 6 7 8 9 a b c d e f 10
1 2 3 4 5 6 7 8 9 a b c d e f 10
1 1300 1400 1500 0 0  0 0 0 0 ffffffff 0 0 0 0
5
fffffffb

// File: compile.f
rtl/conv_pkg.sv
rtl/conv_fifo.sv
rtl/conv_sequencer.sv
rtl/conv_pe.sv
rtl/conv_result.sv
rtl/conv_compute.sv
tb/conv_checker.sv
tb/tb_conv_compute.sv

// File: run_sim.sh
#!/bin/bash
# builds and runs the convolution testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_conv_compute \
    -f compile.f -o sim_conv
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_conv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Done: no errors$"; then
    exit 0
else
    exit 1
fi

// File: tb/tb_conv_compute.sv
`timescale 1ns/1ps

module tb_conv_compute;

    logic clk = 1'b0;
    logic write_counter_rst;
    logic start;
    logic [conv_pkg::DIM_W-1:0] fm_dim;
    logic [conv_pkg::AWIDTH-1:0] wt_offset;
    logic [conv_pkg::AWIDTH-1:0] ifm_offset;
    logic [conv_pkg::AWIDTH-1:0] ofm_offset;
    logic idle;
    logic write_error;
    logic [conv_pkg::AWIDTH-1:0] req_read_addr;
    logic [conv_pkg::AWIDTH-1:0] req_read_len;
    logic req_read_addr_valid;
    logic req_read_addr_ready = 1'b0;
    logic [conv_pkg::DWIDTH-1:0] rdata = '0;
    logic rdata_valid = 1'b0;
    logic rdata_ready;
    logic [conv_pkg::AWIDTH-1:0] req_write_addr;
    logic [conv_pkg::AWIDTH-1:0] req_write_len;
    logic req_write_addr_valid;
    logic req_write_addr_ready = 1'b0;
    logic [conv_pkg::DWIDTH-1:0] req_write_data;
    logic req_write_data_valid;
    logic req_write_data_ready = 1'b0;
    logic resp_write_status = 1'b0;
    logic resp_write_status_valid = 1'b0;
    logic resp_write_status_ready;

    logic [31:0] stim [0:1023];
    logic [31:0] mem [int];
    logic [31:0] exp_ofm [64];
    logic stall;
    logic job_err;
    int job_id;
    int seed = 77587;
    int timeouts;
    int chk_errors;
    int rd_left;
    int rd_addr;
    int wr_seen;
    int p;
    int njobs;

    always #10 clk = ~clk;

    conv_compute i_conv_compute (.*);

    conv_checker i_checker (
        .clk(clk),
        .write_counter_rst(write_counter_rst),
        .start(start),
        .idle(idle),
        .fm_dim(fm_dim),
        .wt_offset(wt_offset),
        .ifm_offset(ifm_offset),
        .ofm_offset(ofm_offset),
        .write_error(write_error),
        .req_read_addr(req_read_addr),
        .req_read_len(req_read_len),
        .req_read_addr_valid(req_read_addr_valid),
        .req_read_addr_ready(req_read_addr_ready),
        .req_write_addr(req_write_addr),
        .req_write_len(req_write_len),
        .req_write_addr_valid(req_write_addr_valid),
        .req_write_addr_ready(req_write_addr_ready),
        .req_write_data(req_write_data),
        .req_write_data_valid(req_write_data_valid),
        .req_write_data_ready(req_write_data_ready),
        .resp_write_status_valid(resp_write_status_valid),
        .resp_write_status_ready(resp_write_status_ready),
        .job_id(job_id),
        .exp_err(job_err),
        .exp_ofm(exp_ofm),
        .errors(chk_errors)
    );

    // memory model, word addressed
    always @(posedge clk) begin : mem_model
        int left;
        int addr;
        if (write_counter_rst) begin
            rd_left <= 0;
            rd_addr <= 0;
            rdata <= '0;
            rdata_valid <= 1'b0;
            req_read_addr_ready <= 1'b0;
            req_write_addr_ready <= 1'b0;
            req_write_data_ready <= 1'b0;
            resp_write_status <= 1'b0;
            resp_write_status_valid <= 1'b0;
            wr_seen <= 0;
        end else begin
            left = rd_left;
            addr = rd_addr;
            if (rdata_valid && rdata_ready) begin
                left = left - 1;
                addr = addr + 1;
            end
            if (req_read_addr_valid && req_read_addr_ready) begin
                left = int'(req_read_len);
                addr = int'(req_read_addr);
            end
            rd_left <= left;
            rd_addr <= addr;
            // a word once offered stays until taken
            if (!(rdata_valid && !rdata_ready)) begin
                if (left > 0 && (!stall || (($random(seed) & 1) == 1))) begin
                    rdata_valid <= 1'b1;
                    rdata <= mem.exists(addr) ? mem[addr] : 32'h0;
                end else begin
                    rdata_valid <= 1'b0;
                end
            end
            req_read_addr_ready <= 1'b1;
            req_write_addr_ready <= 1'b1;
            req_write_data_ready <= !stall || (($random(seed) & 1) == 1);
            resp_write_status_valid <= 1'b0;
            if (req_write_data_valid && req_write_data_ready) begin
                if (wr_seen + 1 == int'(fm_dim) * int'(fm_dim)) begin
                    wr_seen <= 0;
                    resp_write_status_valid <= 1'b1;
                    resp_write_status <= job_err;
                end else begin
                    wr_seen <= wr_seen + 1;
                end
            end
        end
    end

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (!idle && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (!idle) begin
            $display("Timeout: job %0d did not return to idle in %0d cycles", job_id, limit);
            timeouts++;
        end
    endtask

    // one job from the stim array, p points at its first word
    task automatic load_job();
        int n;
        n = int'(stim[p]);
        fm_dim <= stim[p][conv_pkg::DIM_W-1:0];
        wt_offset <= stim[p+1];
        ifm_offset <= stim[p+2];
        ofm_offset <= stim[p+3];
        stall <= stim[p+4][0];
        job_err <= stim[p+5][0];
        mem.delete();
        for (int k = 0; k < conv_pkg::NUM_WT; k++) begin
            mem[int'(stim[p+1]) + k] = stim[p+6+k];
        end
        for (int k = 0; k < n * n; k++) begin
            mem[int'(stim[p+2]) + k] = stim[p+15+k];
            exp_ofm[k] = stim[p+15+n*n+k];
        end
        p = p + 15 + 2 * n * n;
    endtask

    initial begin
        write_counter_rst = 1'b1;
        start = 1'b0;
        fm_dim = '0;
        wt_offset = '0;
        ifm_offset = '0;
        ofm_offset = '0;
        stall = 1'b0;
        job_err = 1'b0;
        job_id = 0;
        timeouts = 0;
        $readmemh("tb/conv_stim.txt", stim);
        repeat (8) @(posedge clk);
        write_counter_rst <= 1'b0;
        @(posedge clk);
        wait_idle(100);
        njobs = int'(stim[0]);
        p = 1;
        for (int j = 0; j < njobs; j++) begin
            @(posedge clk);
            job_id <= j;
            load_job();
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            @(posedge clk);
            wait_idle(5000);
        end
        repeat (4) @(posedge clk);
        $display("checker errors: %0d, timeouts: %0d", chk_errors, timeouts);
        if (chk_errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: tb/conv_checker.sv
`timescale 1ns/1ps

module conv_checker (
    input  logic                        clk,
    input  logic                        write_counter_rst,
    input  logic                        start,
    input  logic                        idle,
    input  logic [conv_pkg::DIM_W-1:0]  fm_dim,
    input  logic [conv_pkg::AWIDTH-1:0] wt_offset,
    input  logic [conv_pkg::AWIDTH-1:0] ifm_offset,
    input  logic [conv_pkg::AWIDTH-1:0] ofm_offset,
    input  logic                        write_error,
    input  logic [conv_pkg::AWIDTH-1:0] req_read_addr,
    input  logic [conv_pkg::AWIDTH-1:0] req_read_len,
    input  logic                        req_read_addr_valid,
    input  logic                        req_read_addr_ready,
    input  logic [conv_pkg::AWIDTH-1:0] req_write_addr,
    input  logic [conv_pkg::AWIDTH-1:0] req_write_len,
    input  logic                        req_write_addr_valid,
    input  logic                        req_write_addr_ready,
    input  logic [conv_pkg::DWIDTH-1:0] req_write_data,
    input  logic                        req_write_data_valid,
    input  logic                        req_write_data_ready,
    input  logic                        resp_write_status_valid,
    input  logic                        resp_write_status_ready,
    input  int                          job_id,
    input  logic                        exp_err,
    input  logic [31:0]                 exp_ofm [64],
    output int                          errors
);

    int rd_reqs;
    int wr_reqs;
    int wr_words;
    logic prev_rst = 1'b1;
    logic prev_idle = 1'b1;

    initial errors = 0;

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch job%0d %s expected %h actual %h", job_id, what, exp, act);
            errors++;
        end
    endtask

    always @(posedge clk) begin : watch
        int sq;
        sq = int'(fm_dim) * int'(fm_dim);
        prev_rst <= write_counter_rst;
        prev_idle <= idle;
        if (write_counter_rst) begin
            rd_reqs <= 0;
            wr_reqs <= 0;
            wr_words <= 0;
        end else begin
            if (prev_rst && (!idle || req_read_addr_valid || req_write_addr_valid
                             || req_write_data_valid || write_error)) begin
                $display("Error: DUT not idle or a request valid high after reset");
                errors++;
            end
            if (start && idle) begin
                rd_reqs <= 0;
                wr_reqs <= 0;
                wr_words <= 0;
            end
            if (req_read_addr_valid && req_read_addr_ready) begin
                rd_reqs <= rd_reqs + 1;
                if (rd_reqs == 0) begin
                    compare("weight read addr", wt_offset, req_read_addr);
                    compare("weight read len", 32'd9, req_read_len);
                end else if (rd_reqs == 1) begin
                    compare("map read addr", ifm_offset, req_read_addr);
                    compare("map read len", 32'(sq), req_read_len);
                end else begin
                    $display("Error: job%0d issued more than two read requests", job_id);
                    errors++;
                end
            end
            if (req_write_addr_valid && req_write_addr_ready) begin
                wr_reqs <= wr_reqs + 1;
                compare("write addr", ofm_offset, req_write_addr);
                compare("write len", 32'(sq), req_write_len);
            end
            if (req_write_data_valid && req_write_data_ready) begin
                wr_words <= wr_words + 1;
                if (wr_words >= sq) begin
                    $display("Error: job%0d wrote a word beyond the map", job_id);
                    errors++;
                end else begin
                    compare($sformatf("word %0d", wr_words), exp_ofm[wr_words], req_write_data);
                end
            end
            // status is offered for one cycle only
            if (resp_write_status_valid && !resp_write_status_ready) begin
                $display("Error: job%0d write status offered while the DUT was not ready",
                         job_id);
                errors++;
            end
            // end of a job
            if (idle && !prev_idle && !prev_rst) begin
                compare("word count", 32'(sq), 32'(wr_words));
                compare("write requests", 32'd1, 32'(wr_reqs));
                compare("write_error", {31'b0, exp_err}, {31'b0, write_error});
            end
        end
    end

endmodule

// File: rtl/conv_compute.sv
`timescale 1ns/1ps

module conv_compute (
    input  logic                        clk,
    input  logic                        write_counter_rst,
    input  logic                        start,
    input  logic [conv_pkg::DIM_W-1:0]  fm_dim,
    input  logic [conv_pkg::AWIDTH-1:0] wt_offset,
    input  logic [conv_pkg::AWIDTH-1:0] ifm_offset,
    input  logic [conv_pkg::AWIDTH-1:0] ofm_offset,
    output logic                        idle,
    output logic                        write_error,
    output logic [conv_pkg::AWIDTH-1:0] req_read_addr,
    output logic [conv_pkg::AWIDTH-1:0] req_read_len,
    output logic                        req_read_addr_valid,
    input  logic                        req_read_addr_ready,
    input  logic [conv_pkg::DWIDTH-1:0] rdata,
    input  logic                        rdata_valid,
    output logic                        rdata_ready,
    output logic [conv_pkg::AWIDTH-1:0] req_write_addr,
    output logic [conv_pkg::AWIDTH-1:0] req_write_len,
    output logic                        req_write_addr_valid,
    input  logic                        req_write_addr_ready,
    output logic [conv_pkg::DWIDTH-1:0] req_write_data,
    output logic                        req_write_data_valid,
    input  logic                        req_write_data_ready,
    input  logic                        resp_write_status,
    input  logic                        resp_write_status_valid,
    output logic                        resp_write_status_ready
);

    logic rd_valid;
    logic rd_ready;
    logic [conv_pkg::DWIDTH-1:0] rd_data;
    logic wt_valid;
    logic [conv_pkg::DWIDTH-1:0] wt_data;
    logic [conv_pkg::ROW_W-1:0] wt_row;
    logic px_valid;
    logic [conv_pkg::DWIDTH-1:0] px_data;
    logic job_begin;
    logic job_done;
    logic [conv_pkg::WT_DIM-1:0] part_valid;
    logic [conv_pkg::DWIDTH-1:0] part_data [conv_pkg::WT_DIM];
    logic [conv_pkg::WT_DIM-1:0] head_valid;
    logic [conv_pkg::DWIDTH-1:0] head_data [conv_pkg::WT_DIM];
    logic head_pop;

    // memory read data
    conv_fifo #(
        .LOGDEPTH(conv_pkg::RD_FIFO_LOGDEPTH)
    ) i_rd_fifo (
        .clk(clk),
        .write_counter_rst(write_counter_rst),
        .enq_valid(rdata_valid),
        .enq_data(rdata),
        .enq_ready(rdata_ready),
        .deq_valid(rd_valid),
        .deq_data(rd_data),
        .deq_ready(rd_ready)
    );

    conv_sequencer i_sequencer (
        .clk(clk),
        .write_counter_rst(write_counter_rst),
        .start(start),
        .fm_dim(fm_dim),
        .wt_offset(wt_offset),
        .ifm_offset(ifm_offset),
        .idle(idle),
        .req_read_addr(req_read_addr),
        .req_read_len(req_read_len),
        .req_read_addr_valid(req_read_addr_valid),
        .req_read_addr_ready(req_read_addr_ready),
        .rd_valid(rd_valid),
        .rd_data(rd_data),
        .rd_ready(rd_ready),
        .wt_valid(wt_valid),
        .wt_data(wt_data),
        .wt_row(wt_row),
        .px_valid(px_valid),
        .px_data(px_data),
        .job_begin(job_begin),
        .job_done(job_done)
    );

    // one PE and result FIFO per weight row, FIFO sized so it never fills
    for (genvar g = 0; g < conv_pkg::WT_DIM; g++) begin : g_row
        conv_pe #(
            .ROW(g)
        ) i_pe (
            .clk(clk),
            .write_counter_rst(write_counter_rst),
            .fm_dim(fm_dim),
            .wt_valid(wt_valid),
            .wt_data(wt_data),
            .wt_row(wt_row),
            .px_valid(px_valid),
            .px_data(px_data),
            .part_valid(part_valid[g]),
            .part_data(part_data[g])
        );

        conv_fifo #(
            .LOGDEPTH(conv_pkg::PE_FIFO_LOGDEPTH)
        ) i_pe_fifo (
            .clk(clk),
            .write_counter_rst(write_counter_rst),
            .enq_valid(part_valid[g]),
            .enq_data(part_data[g]),
            .enq_ready(),
            .deq_valid(head_valid[g]),
            .deq_data(head_data[g]),
            .deq_ready(head_pop)
        );
    end

    conv_result i_result (
        .clk(clk),
        .write_counter_rst(write_counter_rst),
        .fm_dim(fm_dim),
        .ofm_offset(ofm_offset),
        .job_begin(job_begin),
        .job_done(job_done),
        .write_error(write_error),
        .head_valid(head_valid),
        .head_data(head_data),
        .head_pop(head_pop),
        .req_write_addr(req_write_addr),
        .req_write_len(req_write_len),
        .req_write_addr_valid(req_write_addr_valid),
        .req_write_addr_ready(req_write_addr_ready),
        .req_write_data(req_write_data),
        .req_write_data_valid(req_write_data_valid),
        .req_write_data_ready(req_write_data_ready),
        .resp_write_status(resp_write_status),
        .resp_write_status_valid(resp_write_status_valid),
        .resp_write_status_ready(resp_write_status_ready)
    );

endmodule

// File: rtl/conv_result.sv
`timescale 1ns/1ps

module conv_result (
    input  logic                        clk,
    input  logic                        write_counter_rst,
    input  logic [conv_pkg::DIM_W-1:0]  fm_dim,
    input  logic [conv_pkg::AWIDTH-1:0] ofm_offset,
    input  logic                        job_begin,
    output logic                        job_done,
    output logic                        write_error,
    input  logic [conv_pkg::WT_DIM-1:0] head_valid,
    input  logic [conv_pkg::DWIDTH-1:0] head_data [conv_pkg::WT_DIM],
    output logic                        head_pop,
    output logic [conv_pkg::AWIDTH-1:0] req_write_addr,
    output logic [conv_pkg::AWIDTH-1:0] req_write_len,
    output logic                        req_write_addr_valid,
    input  logic                        req_write_addr_ready,
    output logic [conv_pkg::DWIDTH-1:0] req_write_data,
    output logic                        req_write_data_valid,
    input  logic                        req_write_data_ready,
    input  logic                        resp_write_status,
    input  logic                        resp_write_status_valid,
    output logic                        resp_write_status_ready
);

    logic [conv_pkg::AWIDTH-1:0] fm_dim_ext;
    logic [conv_pkg::AWIDTH-1:0] fm_sq;
    logic [conv_pkg::AWIDTH-1:0] write_cnt;
    logic [conv_pkg::DWIDTH-1:0] head_sum;
    logic out_free;
    logic wdata_fire;
    logic status_fire;
    logic status_seen;
    logic busy;

    assign fm_dim_ext = {{(conv_pkg::AWIDTH - conv_pkg::DIM_W){1'b0}}, fm_dim};
    assign fm_sq = fm_dim_ext * fm_dim_ext;

    assign req_write_addr = ofm_offset;
    assign req_write_len = fm_sq;
    assign resp_write_status_ready = 1'b1;

    assign wdata_fire = req_write_data_valid & req_write_data_ready;
    assign status_fire = resp_write_status_valid & resp_write_status_ready;

    // one-entry output register, refilled in the cycle it drains
    assign out_free = ~req_write_data_valid | req_write_data_ready;
    assign head_pop = (&head_valid) & out_free;

    always_comb begin
        head_sum = '0;
        for (int i = 0; i < conv_pkg::WT_DIM; i++) begin
            head_sum = head_sum + head_data[i];
        end
    end

    always_ff @(posedge clk) begin
        if (head_pop) begin
            req_write_data <= head_sum;
        end
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            req_write_data_valid <= 1'b0;
        end else if (head_pop) begin
            req_write_data_valid <= 1'b1;
        end else if (req_write_data_ready) begin
            req_write_data_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            busy <= 1'b0;
            req_write_addr_valid <= 1'b0;
            write_cnt <= '0;
            status_seen <= 1'b0;
            write_error <= 1'b0;
            job_done <= 1'b0;
        end else begin
            job_done <= 1'b0;
            if (job_begin) begin
                busy <= 1'b1;
                req_write_addr_valid <= 1'b1;
                write_cnt <= '0;
                status_seen <= 1'b0;
                write_error <= 1'b0;
            end else begin
                if (req_write_addr_ready) begin
                    req_write_addr_valid <= 1'b0;
                end
                if (wdata_fire) begin
                    write_cnt <= write_cnt + 1'b1;
                end
                // status 1 means the memory rejected the write
                if (status_fire) begin
                    status_seen <= 1'b1;
                    if (resp_write_status) begin
                        write_error <= 1'b1;
                    end
                end
                if (busy && status_seen && (write_cnt == fm_sq)) begin
                    busy <= 1'b0;
                    job_done <= 1'b1;
                end
            end
        end
    end

endmodule

// File: rtl/conv_pe.sv
`timescale 1ns/1ps

module conv_pe #(
    parameter int ROW = 0
) (
    input  logic                        clk,
    input  logic                        write_counter_rst,
    input  logic [conv_pkg::DIM_W-1:0]  fm_dim,
    input  logic                        wt_valid,
    input  logic [conv_pkg::DWIDTH-1:0] wt_data,
    input  logic [conv_pkg::ROW_W-1:0]  wt_row,
    input  logic                        px_valid,
    input  logic [conv_pkg::DWIDTH-1:0] px_data,
    output logic                        part_valid,
    output logic [conv_pkg::DWIDTH-1:0] part_data
);

    logic [conv_pkg::DWIDTH-1:0] wt [conv_pkg::WT_DIM];
    logic [conv_pkg::ROW_W-1:0] wt_col;
    logic [conv_pkg::DWIDTH-1:0] p0;
    logic [conv_pkg::DWIDTH-1:0] p1;
    logic [conv_pkg::DIM_W-1:0] col;
    logic [conv_pkg::DIM_W-1:0] row;
    logic wt_hit;
    logic row_hit;
    logic col_hit;
    logic [conv_pkg::DWIDTH-1:0] dot;

    assign wt_hit = wt_valid && (wt_row == ROW);

    // padded rows ROW..ROW+fm_dim-1, window full from column 2
    assign row_hit = (row >= ROW) && (row < ROW + fm_dim);
    assign col_hit = (col >= conv_pkg::WT_DIM - 1);

    // 32-bit wrap, low bits match signed arithmetic
    assign dot = wt[0] * p0 + wt[1] * p1 + wt[2] * px_data;

    always_ff @(posedge clk) begin
        if (wt_hit) begin
            wt[wt_col] <= wt_data;
        end
    end

    always_ff @(posedge clk) begin
        if (px_valid) begin
            p1 <= px_data;
            p0 <= p1;
            part_data <= dot;
        end
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            wt_col <= '0;
            col <= '0;
            row <= '0;
            part_valid <= 1'b0;
        end else begin
            if (wt_hit) begin
                wt_col <= (wt_col == conv_pkg::WT_DIM - 1) ? '0 : wt_col + 1'b1;
            end
            part_valid <= px_valid && row_hit && col_hit;
            if (px_valid) begin
                if (col == fm_dim + 1'b1) begin
                    col <= '0;
                    row <= (row == fm_dim + 1'b1) ? '0 : row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

endmodule

// File: rtl/conv_sequencer.sv
`timescale 1ns/1ps

module conv_sequencer (
    input  logic                        clk,
    input  logic                        write_counter_rst,
    input  logic                        start,
    input  logic [conv_pkg::DIM_W-1:0]  fm_dim,
    input  logic [conv_pkg::AWIDTH-1:0] wt_offset,
    input  logic [conv_pkg::AWIDTH-1:0] ifm_offset,
    output logic                        idle,
    output logic [conv_pkg::AWIDTH-1:0] req_read_addr,
    output logic [conv_pkg::AWIDTH-1:0] req_read_len,
    output logic                        req_read_addr_valid,
    input  logic                        req_read_addr_ready,
    input  logic                        rd_valid,
    input  logic [conv_pkg::DWIDTH-1:0] rd_data,
    output logic                        rd_ready,
    output logic                        wt_valid,
    output logic [conv_pkg::DWIDTH-1:0] wt_data,
    output logic [conv_pkg::ROW_W-1:0]  wt_row,
    output logic                        px_valid,
    output logic [conv_pkg::DWIDTH-1:0] px_data,
    output logic                        job_begin,
    input  logic                        job_done
);

    logic [2:0] state;
    logic rd_addr_valid;
    logic [conv_pkg::ROW_W-1:0] m_cnt;
    logic [conv_pkg::ROW_W-1:0] n_cnt;
    logic [conv_pkg::DIM_W-1:0] x_cnt;
    logic [conv_pkg::DIM_W-1:0] y_cnt;
    logic [conv_pkg::AWIDTH-1:0] fm_dim_ext;
    logic rd_fire;
    logic x_last;
    logic y_last;
    logic halo;
    logic step;

    assign fm_dim_ext = {{(conv_pkg::AWIDTH - conv_pkg::DIM_W){1'b0}}, fm_dim};
    assign idle = (state == conv_pkg::ST_IDLE);

    // read requests, address and length follow the request state
    assign req_read_addr_valid = rd_addr_valid;
    assign req_read_addr = (state == conv_pkg::ST_REQ_FM) ? ifm_offset : wt_offset;
    assign req_read_len = (state == conv_pkg::ST_REQ_FM) ? fm_dim_ext * fm_dim_ext
                                                         : conv_pkg::AWIDTH'(conv_pkg::NUM_WT);

    // halo from counter values alone
    assign x_last = (x_cnt == fm_dim + 1'b1);
    assign y_last = (y_cnt == fm_dim + 1'b1);
    assign halo = (x_cnt == '0) | (y_cnt == '0) | x_last | y_last;

    assign rd_ready = (state == conv_pkg::ST_LOAD_WT) | ((state == conv_pkg::ST_LOAD_FM) & ~halo);
    assign rd_fire = rd_valid & rd_ready;
    assign step = (state == conv_pkg::ST_LOAD_FM) & (halo | rd_valid);

    assign wt_valid = (state == conv_pkg::ST_LOAD_WT) & rd_valid;
    assign wt_data = rd_data;
    assign wt_row = m_cnt;

    assign px_valid = step;
    assign px_data = halo ? '0 : rd_data;

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            state <= conv_pkg::ST_IDLE;
            rd_addr_valid <= 1'b0;
            job_begin <= 1'b0;
            m_cnt <= '0;
            n_cnt <= '0;
            x_cnt <= '0;
            y_cnt <= '0;
        end else begin
            job_begin <= 1'b0;
            case (state)
                conv_pkg::ST_IDLE: begin
                    if (start) begin
                        state <= conv_pkg::ST_REQ_WT;
                        rd_addr_valid <= 1'b1;
                        job_begin <= 1'b1;
                    end
                end
                conv_pkg::ST_REQ_WT: begin
                    if (req_read_addr_ready) begin
                        state <= conv_pkg::ST_LOAD_WT;
                        rd_addr_valid <= 1'b0;
                    end
                end
                conv_pkg::ST_LOAD_WT: begin
                    // n walks a weight row, m picks the row
                    if (rd_fire) begin
                        if (n_cnt == conv_pkg::WT_DIM - 1) begin
                            n_cnt <= '0;
                            if (m_cnt == conv_pkg::WT_DIM - 1) begin
                                m_cnt <= '0;
                                state <= conv_pkg::ST_REQ_FM;
                                rd_addr_valid <= 1'b1;
                            end else begin
                                m_cnt <= m_cnt + 1'b1;
                            end
                        end else begin
                            n_cnt <= n_cnt + 1'b1;
                        end
                    end
                end
                conv_pkg::ST_REQ_FM: begin
                    if (req_read_addr_ready) begin
                        state <= conv_pkg::ST_LOAD_FM;
                        rd_addr_valid <= 1'b0;
                    end
                end
                conv_pkg::ST_LOAD_FM: begin
                    // padded raster, one position per step
                    if (step) begin
                        if (x_last) begin
                            x_cnt <= '0;
                            if (y_last) begin
                                y_cnt <= '0;
                                state <= conv_pkg::ST_DRAIN;
                            end else begin
                                y_cnt <= y_cnt + 1'b1;
                            end
                        end else begin
                            x_cnt <= x_cnt + 1'b1;
                        end
                    end
                end
                conv_pkg::ST_DRAIN: begin
                    if (job_done) begin
                        state <= conv_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= conv_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: rtl/conv_fifo.sv
`timescale 1ns/1ps

module conv_fifo #(
    parameter int LOGDEPTH = 4
) (
    input  logic                        clk,
    input  logic                        write_counter_rst,
    input  logic                        enq_valid,
    input  logic [conv_pkg::DWIDTH-1:0] enq_data,
    output logic                        enq_ready,
    output logic                        deq_valid,
    output logic [conv_pkg::DWIDTH-1:0] deq_data,
    input  logic                        deq_ready
);

    logic [conv_pkg::DWIDTH-1:0] mem [2**LOGDEPTH];
    logic [LOGDEPTH-1:0] wr_ptr;
    logic [LOGDEPTH-1:0] rd_ptr;
    logic [LOGDEPTH:0] count;
    logic enq_fire;
    logic deq_fire;

    assign enq_fire = enq_valid & enq_ready;
    assign deq_fire = deq_valid & deq_ready;

    // top count bit set means full
    assign enq_ready = ~count[LOGDEPTH];
    assign deq_valid = (count != '0);
    assign deq_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            mem[wr_ptr] <= enq_data;
        end
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (enq_fire && !deq_fire) begin
                count <= count + 1'b1;
            end else if (deq_fire && !enq_fire) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: rtl/conv_pkg.sv
package conv_pkg;

    // data and address widths
    localparam int DWIDTH = 32;
    localparam int AWIDTH = 32;

    // 3x3 kernel, one PE per weight row
    localparam int WT_DIM = 3;
    localparam int NUM_WT = WT_DIM * WT_DIM;
    localparam int ROW_W = $clog2(WT_DIM);

    // map side limit, counters must hold MAX_FM_DIM+2
    localparam int MAX_FM_DIM = 8;
    localparam int DIM_W = 4;

    localparam int PE_FIFO_LOGDEPTH = 6;
    localparam int RD_FIFO_LOGDEPTH = 4;

    // sequencer states
    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_REQ_WT = 3'd1;
    localparam logic [2:0] ST_LOAD_WT = 3'd2;
    localparam logic [2:0] ST_REQ_FM = 3'd3;
    localparam logic [2:0] ST_LOAD_FM = 3'd4;
    localparam logic [2:0] ST_DRAIN = 3'd5;

endpackage
